//--- all.f
+incdir+verif
src/cart_pkg.sv
src/map_state_if.sv
src/bank_lookup_if.sv
src/crt_bank_table.sv
src/cart_mapper.sv
src/address_map.sv
src/cartridge.sv
verif/tb_clock_gen.sv
verif/tb_cartridge.sv

//--- verif/cart_model.svh
// Cartridge mapper reference model
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

// Bank table and loaded bank count
logic [6:0] m_lo_tab [64];
logic [6:0] m_hi_tab [64];
logic [7:0] m_count;

// Mapper registers
logic [6:0] m_bank_lo;
logic [6:0] m_bank_hi;
logic       m_lo_from_tab;
logic       m_hi_from_tab;
logic       m_exrom;
logic       m_game;
logic       m_iof_ena;
logic       m_iof_wr;

function automatic void model_store_bank(input int num, input logic [15:0] laddr,
		input logic [15:0] size, input logic [22:0] raddr);
	logic [6:0] b;
	b = raddr[19:13];
	if (num < 64) begin
		if (laddr <= 16'h8000) begin
			m_lo_tab[num] = b;
			// 16K chip, upper half is the next bank
			if (size > 16'h2000)
				m_hi_tab[num] = b + 7'd1;
		end else begin
			m_hi_tab[num] = b;
		end
	end
	m_count = m_count + 8'd1;
endfunction

// Reset state, then the initial state of the type
function automatic void model_init(input logic [15:0] id, input logic [7:0] exr,
		input logic [7:0] gm);
	m_bank_lo     = 7'd0;
	m_bank_hi     = 7'd0;
	m_lo_from_tab = 1'b0;
	m_hi_from_tab = 1'b0;
	m_exrom       = 1'b1;
	m_game        = 1'b1;
	m_iof_ena     = 1'b0;
	m_iof_wr      = 1'b0;
	case (id)
		CART_GENERIC: begin
			m_exrom       = exr[0];
			m_game        = gm[0];
			m_lo_from_tab = 1'b1;
			m_hi_from_tab = 1'b1;
		end
		CART_SIMONS: begin
			m_exrom   = 1'b0;
			m_game    = 1'b0;
			m_bank_hi = 7'd1;
		end
		CART_OCEAN: begin
			m_exrom = 1'b0;
			m_game  = (m_count > 8'd32);
		end
		CART_C64GS, CART_MAGIC_DESK: begin
			m_exrom = 1'b0;
			m_game  = 1'b1;
		end
		CART_EASYFLASH, CART_XBANK: begin
			m_exrom       = (id == CART_EASYFLASH);
			m_game        = 1'b0;
			m_iof_ena     = 1'b1;
			m_iof_wr      = 1'b1;
			m_lo_from_tab = 1'b1;
			m_hi_from_tab = 1'b1;
		end
		default: ;
	endcase
endfunction

// Register effect of one IOE access
function automatic void model_io(input logic [15:0] id, input bit wr,
		input logic [15:0] addr, input logic [7:0] data);
	logic [6:0] mask;
	mask = (m_count <= 8'd16) ? 7'h0F : (m_count <= 8'd32) ? 7'h1F :
		(m_count <= 8'd64) ? 7'h3F : 7'h7F;
	case (id)
		CART_SIMONS:
			m_game = !wr;
		CART_OCEAN: begin
			if (wr) begin
				m_bank_lo = {1'b0, data[5:0]};
				m_bank_hi = {1'b0, data[5:0]};
			end
		end
		CART_C64GS:
			m_bank_lo = wr ? {1'b0, addr[5:0]} : 7'd0;
		CART_MAGIC_DESK: begin
			if (wr) begin
				m_bank_lo = data[6:0] & mask;
				m_exrom   = data[7];
			end
		end
		CART_EASYFLASH, CART_XBANK: begin
			if (wr && addr[1]) begin
				m_game  = !data[0] && data[2];
				m_exrom = !data[1];
			end else if (wr) begin
				m_bank_lo = {1'b0, data[5:0]};
				m_bank_hi = {1'b0, data[5:0]};
			end
		end
		default: ;
	endcase
endfunction

function automatic bit model_iof_sel(input bit iof, input bit wr);
	return iof && (wr ? m_iof_wr : m_iof_ena);
endfunction

function automatic logic [22:0] model_addr(input bit rst, input bit roml, input bit romh,
		input bit umax, input bit iof, input bit wr, input logic [15:0] addr);
	logic [6:0]  lo;
	logic [6:0]  hi;
	logic [9:0]  lo_rom;
	logic [9:0]  hi_rom;
	logic [22:0] a;
	lo     = m_lo_from_tab ? m_lo_tab[m_bank_lo[5:0]] : m_bank_lo;
	hi     = m_hi_from_tab ? m_hi_tab[m_bank_hi[5:0]] : m_bank_hi;
	lo_rom = 10'd128 + lo;
	hi_rom = 10'd128 + hi;
	a      = {7'd0, addr};
	if (!rst) begin
		if (romh && !wr)
			a[22:13] = hi_rom;
		if (roml && !wr)
			a[22:13] = lo_rom;
		// RAM bank 0 sits at SDRAM bank 8
		if (model_iof_sel(iof, wr) && m_iof_wr)
			a[22:13] = 10'd8;
		if (umax)
			a[22:12] = {hi_rom, 1'b1};
	end
	return a;
endfunction

`endif

//--- verif/tb_cartridge.sv
// Cartridge mapper testbench
`timescale 1ns/10ps
`default_nettype none

module tb_cartridge;
	import cart_pkg::*;

	localparam int N_LOADS     = 8;
	localparam int MAX_LOAD    = 82;
	localparam int N_ACCESS    = 60;
	localparam int TEST_CYCLES = 16 + N_LOADS * (MAX_LOAD + 3 * N_ACCESS);
	localparam int CYCLE_LIMIT = TEST_CYCLES + 200;

	logic        clk32;
	logic        reset_n;
	logic        cart_loading;
	cart_id_t    cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	logic [15:0] cart_bank_num;
	sdram_addr_t cart_bank_raddr;
	logic        cart_bank_wr;
	logic        romL;
	logic        romH;
	logic        UMAXromH;
	logic        IOE;
	logic        IOF;
	logic        mem_write;
	logic        mem_ce;
	cpu_addr_t   addr_in;
	cpu_data_t   data_in;
	logic        exrom;
	logic        game;
	logic        IO_rom;
	logic        mem_ce_out;
	logic        mem_write_out;
	sdram_addr_t addr_out;
	logic [31:0] rng_state = 32'd41;
	int          cycle_count = 0;

	`include "cart_model.svh"

	tb_clock_gen clock_gen (.clk32(clk32), .reset_n(reset_n));

	cartridge #(.BANK_SLOTS(64)) dut (
		.clk32(clk32), .reset_n(reset_n), .cart_loading(cart_loading), .cart_id(cart_id),
		.cart_exrom(cart_exrom), .cart_game(cart_game), .cart_bank_laddr(cart_bank_laddr),
		.cart_bank_size(cart_bank_size), .cart_bank_num(cart_bank_num),
		.cart_bank_raddr(cart_bank_raddr), .cart_bank_wr(cart_bank_wr),
		.exrom(exrom), .game(game), .romL(romL), .romH(romH), .UMAXromH(UMAXromH),
		.IOE(IOE), .IOF(IOF), .mem_write(mem_write), .mem_ce(mem_ce), .addr_in(addr_in),
		.data_in(data_in), .IO_rom(IO_rom), .mem_ce_out(mem_ce_out),
		.mem_write_out(mem_write_out), .addr_out(addr_out)
	);

	always @(posedge clk32) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d clock cycles", cycle_count);
			$display("Test FAILED");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	function automatic int unsigned rand_below(input int unsigned n);
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return (rng_state >> 8) % n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// *************************************************************************
	// CRT image loading
	// *************************************************************************
	task automatic load_image(input cart_id_t id, input int n, input bit fill);
		int          i;
		logic [7:0]  exr;
		logic [7:0]  gm;
		logic [15:0] laddr;
		logic [15:0] size;
		logic [22:0] raddr;
		exr = 8'(rand_below(256));
		gm  = 8'(rand_below(256));
		@(posedge clk32);
		cart_id      <= id;
		cart_exrom   <= exr;
		cart_game    <= gm;
		cart_loading <= 1'b1;
		m_count = 8'd0;
		for (i = 0; i < n; i++) begin
			@(posedge clk32);
			laddr = 16'h8000;
			size  = 16'h4000;
			if (!fill) begin
				laddr = rand_below(2) ? 16'h8000 : (rand_below(2) ? 16'hA000 : 16'hE000);
				size  = rand_below(2) ? 16'h2000 : 16'h4000;
			end
			raddr = 23'(rand_below(32'h80_0000));
			cart_bank_wr    <= 1'b1;
			cart_bank_num   <= 16'(i);
			cart_bank_laddr <= laddr;
			cart_bank_size  <= size;
			cart_bank_raddr <= raddr;
			model_store_bank(i, laddr, size, raddr);
			// Mapper sits in its reset state right after the type change
			if (i == 0) begin
				@(negedge clk32);
				check_value("exrom", exrom, 1);
				check_value("game", game, 1);
				check_value("addr_out", addr_out, {7'd0, addr_in});
			end
		end
		@(posedge clk32);
		cart_bank_wr <= 1'b0;
		cart_loading <= 1'b0;
		model_init(id, exr, gm);
	endtask

	// *************************************************************************
	// CPU accesses
	// *************************************************************************
	task automatic bus_cycle(input bit ioe, input bit iof, input bit roml, input bit romh,
			input bit umax, input bit wr, input logic [15:0] addr, input logic [7:0] data,
			input int cycles);
		int k;
		bit ce;
		ce = rand_below(2);
		@(posedge clk32);
		IOE       <= ioe;
		IOF       <= iof;
		romL      <= roml;
		romH      <= romh;
		UMAXromH  <= umax;
		mem_write <= wr;
		mem_ce    <= ce;
		addr_in   <= addr;
		data_in   <= data;
		for (k = 0; k < cycles; k++) begin
			@(negedge clk32);
			check_value("exrom", exrom, m_exrom);
			check_value("game", game, m_game);
			check_value("addr_out", addr_out,
				model_addr(reset_n, roml, romh, umax, iof, wr, addr));
			check_value("mem_write_out", mem_write_out, wr && !(roml && m_exrom && !m_game));
			check_value("IO_rom", IO_rom, iof && m_iof_ena);
			// Strobe only in the first cycle of IOF
			check_value("mem_ce_out", mem_ce_out, ce || (model_iof_sel(iof, wr) && k == 0));
			@(posedge clk32);
			if (ioe && k == 0)
				model_io(cart_id, wr, addr, data);
		end
		IOE       <= 1'b0;
		IOF       <= 1'b0;
		romL      <= 1'b0;
		romH      <= 1'b0;
		UMAXromH  <= 1'b0;
		mem_write <= 1'b0;
		mem_ce    <= 1'b0;
	endtask

	task automatic run_accesses(input int count);
		int         k;
		logic [7:0] d;
		for (k = 0; k < count; k++) begin
			d = 8'(rand_below(256));
			case (rand_below(8))
				0, 1: bus_cycle(1, 0, 0, 0, 0, 1, 16'hDE00 + 16'(rand_below(256)), d, 1);
				2: bus_cycle(1, 0, 0, 0, 0, 0, 16'hDE00 + 16'(rand_below(256)), d, 1);
				3: bus_cycle(0, 1, 0, 0, 0, rand_below(2), 16'hDF00 + 16'(rand_below(256)), d, 2);
				4: bus_cycle(0, 0, 1, 0, 0, 0, 16'h8000 + 16'(rand_below(8192)), d, 1);
				5: bus_cycle(0, 0, 1, 0, 0, 1, 16'h8000 + 16'(rand_below(8192)), d, 1);
				6: bus_cycle(0, 0, 0, 1, 0, 0, (rand_below(2) ? 16'hA000 : 16'hE000) +
					16'(rand_below(8192)), d, 1);
				default: bus_cycle(0, 0, 0, 0, 1, 0, 16'(rand_below(65536)), d, 1);
			endcase
		end
	endtask

	initial begin
		logic [15:0] a;
		cart_loading    = 1'b0;
		cart_id         = 16'hFFFF;
		cart_exrom      = 8'd0;
		cart_game       = 8'd0;
		cart_bank_laddr = 16'd0;
		cart_bank_size  = 16'd0;
		cart_bank_num   = 16'd0;
		cart_bank_raddr = '0;
		cart_bank_wr    = 1'b0;
		romL            = 1'b0;
		romH            = 1'b0;
		UMAXromH        = 1'b0;
		IOE             = 1'b0;
		IOF             = 1'b0;
		mem_write       = 1'b0;
		mem_ce          = 1'b0;
		addr_in         = '0;
		data_in         = '0;
		m_count         = 8'd0;
		model_init(16'hFFFF, 8'd0, 8'd0);

		// No translation while reset is high
		a = 16'h8000 + 16'(rand_below(8192));
		@(posedge clk32);
		romL    <= 1'b1;
		addr_in <= a;
		@(negedge clk32);
		check_value("exrom", exrom, 1);
		check_value("game", game, 1);
		check_value("addr_out", addr_out, model_addr(reset_n, 1, 0, 0, 0, 0, a));
		while (reset_n)
			@(posedge clk32);
		romL <= 1'b0;

		// First image fills both table halves in every slot
		load_image(CART_GENERIC, 64, 1'b1);
		run_accesses(N_ACCESS);
		load_image(CART_OCEAN, 40, 1'b0);
		run_accesses(N_ACCESS);
		load_image(CART_C64GS, 8 + rand_below(17), 1'b0);
		run_accesses(N_ACCESS);
		load_image(CART_MAGIC_DESK, 1 + rand_below(80), 1'b0);
		run_accesses(N_ACCESS);
		load_image(CART_EASYFLASH, 16 + rand_below(49), 1'b0);
		run_accesses(N_ACCESS);
		load_image(CART_SIMONS, 2 + rand_below(16), 1'b0);
		run_accesses(N_ACCESS);
		load_image(CART_XBANK, 16 + rand_below(49), 1'b0);
		run_accesses(N_ACCESS);
		load_image(CART_GENERIC, 1 + rand_below(64), 1'b0);
		run_accesses(N_ACCESS);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 8
) (
	output logic clk32,
	output logic reset_n
);

	initial begin
		clk32 = 1'b0;
		forever #HALF_PERIOD clk32 = ~clk32;
	end

	// Reset is high for the first cycles
	initial begin
		reset_n = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk32);
		reset_n <= 1'b0;
	end

endmodule

`default_nettype wire

//--- src/cartridge.sv
// C64 cartridge bank mapper
`timescale 1ns/10ps
`default_nettype none

module cartridge #(
	parameter int BANK_SLOTS = 64
) (
	input  wire                        clk32,
	input  wire                        reset_n,

	// CRT loader
	input  wire                        cart_loading,
	input  wire cart_pkg::cart_id_t    cart_id,
	input  wire [7:0]                  cart_exrom,
	input  wire [7:0]                  cart_game,
	input  wire [15:0]                 cart_bank_laddr,
	input  wire [15:0]                 cart_bank_size,
	input  wire [15:0]                 cart_bank_num,
	input  wire cart_pkg::sdram_addr_t cart_bank_raddr,
	input  wire                        cart_bank_wr,

	// Expansion port lines
	output logic                       exrom,
	output logic                       game,

	// CPU and VIC side
	input  wire                        romL,
	input  wire                        romH,
	input  wire                        UMAXromH,
	input  wire                        IOE,
	input  wire                        IOF,
	input  wire                        mem_write,
	input  wire                        mem_ce,
	input  wire cart_pkg::cpu_addr_t   addr_in,
	input  wire cart_pkg::cpu_data_t   data_in,
	output logic                       IO_rom,
	output logic                       mem_ce_out,
	output logic                       mem_write_out,
	output cart_pkg::sdram_addr_t      addr_out
);

	cart_pkg::bank_count_t bank_count;

	map_state_if   map_state ();
	bank_lookup_if bank_lookup ();

	crt_bank_table #(
		.BANK_SLOTS(BANK_SLOTS)
	) u_bank_table (
		.clk32(clk32), .cart_loading(cart_loading), .cart_bank_wr(cart_bank_wr),
		.cart_bank_num(cart_bank_num), .cart_bank_laddr(cart_bank_laddr),
		.cart_bank_size(cart_bank_size), .cart_bank_raddr(cart_bank_raddr),
		.bank_count(bank_count), .lookup(bank_lookup.bank_table)
	);

	cart_mapper u_mapper (
		.clk32(clk32), .reset_n(reset_n), .cart_id(cart_id),
		.cart_exrom(cart_exrom), .cart_game(cart_game), .IOE(IOE), .IOF(IOF),
		.mem_write(mem_write), .addr_in(addr_in), .data_in(data_in),
		.bank_count(bank_count), .exrom(exrom), .game(game),
		.state(map_state.mapper)
	);

	address_map u_address_map (
		.romL(romL), .romH(romH), .UMAXromH(UMAXromH), .IOF(IOF),
		.mem_write(mem_write), .mem_ce(mem_ce), .reset_n(reset_n), .addr_in(addr_in),
		.mem_ce_out(mem_ce_out), .mem_write_out(mem_write_out), .IO_rom(IO_rom),
		.addr_out(addr_out), .state(map_state.translator),
		.lookup(bank_lookup.translator)
	);

endmodule

`default_nettype wire

//--- src/address_map.sv
// CPU to SDRAM address translation
`timescale 1ns/10ps
`default_nettype none

module address_map (
	input  wire                      romL,
	input  wire                      romH,
	input  wire                      UMAXromH,
	input  wire                      IOF,
	input  wire                      mem_write,
	input  wire                      mem_ce,
	input  wire                      reset_n,
	input  wire cart_pkg::cpu_addr_t addr_in,
	output logic                     mem_ce_out,
	output logic                     mem_write_out,
	output logic                     IO_rom,
	output cart_pkg::sdram_addr_t    addr_out,
	map_state_if.translator          state,
	bank_lookup_if.translator        lookup
);
	import cart_pkg::*;

	// Zero bits above the 8-bit SDRAM bank
	localparam int PAD_W = $bits(sdram_addr_t) - BANK_OFFSET_BITS - $bits(phys_bank_t);

	bank_t lo_bank;
	bank_t hi_bank;
	logic  cs_iof;

	function automatic phys_bank_t rom_bank(input bank_t b);
		phys_bank_t pb;
		pb = phys_bank_t'(b);
		pb[ROM_REGION_BIT] = 1'b1;
		return pb;
	endfunction

	assign lookup.lo_index = state.bank_lo;
	assign lookup.hi_index = state.bank_hi;

	// Bank per window, through the table or taken as is
	assign lo_bank = state.lo_from_table ? lookup.lo_bank : state.bank_lo;
	assign hi_bank = state.hi_from_table ? lookup.hi_bank : state.bank_hi;

	assign cs_iof     = IOF & (mem_write ? state.iof_wr_ena : state.iof_ena);
	assign IO_rom     = IOF & state.iof_ena;
	assign mem_ce_out = mem_ce | (cs_iof & state.iof_strobe);

	// No RAM sits under ROML in Ultimax, so the write is dropped
	assign mem_write_out = mem_write & ~(romL & state.exrom_override & ~state.game_override);

	always_comb begin
		addr_out = sdram_addr_t'(addr_in);
		if (!reset_n) begin
			if (romH && !mem_write)
				addr_out[22:BANK_OFFSET_BITS] = {{PAD_W{1'b0}}, rom_bank(hi_bank)};
			if (romL && !mem_write)
				addr_out[22:BANK_OFFSET_BITS] = {{PAD_W{1'b0}}, rom_bank(lo_bank)};
			// DFxx RAM page
			if (cs_iof && state.iof_wr_ena)
				addr_out[22:BANK_OFFSET_BITS] = {{PAD_W{1'b0}}, RAM_REGION_BASE};
			// VIC fetch in Ultimax sees the upper 4K of ROMH
			if (UMAXromH)
				addr_out[22:BANK_OFFSET_BITS-1] = {{PAD_W{1'b0}}, rom_bank(hi_bank), 1'b1};
		end
	end

endmodule

`default_nettype wire

//--- src/cart_mapper.sv
// Cartridge type register logic
`timescale 1ns/10ps
`default_nettype none

module cart_mapper (
	input  wire                        clk32,
	input  wire                        reset_n,
	input  wire cart_pkg::cart_id_t    cart_id,
	input  wire [7:0]                  cart_exrom,
	input  wire [7:0]                  cart_game,
	input  wire                        IOE,
	input  wire                        IOF,
	input  wire                        mem_write,
	input  wire cart_pkg::cpu_addr_t   addr_in,
	input  wire cart_pkg::cpu_data_t   data_in,
	input  wire cart_pkg::bank_count_t bank_count,
	output logic                       exrom,
	output logic                       game,
	map_state_if.mapper                state
);
	import cart_pkg::*;

	bank_t    bank_lo;
	bank_t    bank_hi;
	logic     lo_from_table;
	logic     hi_from_table;
	logic     exrom_override;
	logic     game_override;
	logic     iof_ena;
	logic     iof_wr_ena;

	logic     old_ioe;
	logic     old_iof;
	logic     init_n;
	cart_id_t old_id;

	logic     stb_ioe;
	logic     stb_iof;
	logic     ioe_wr;
	logic     ioe_rd;

	// **************************************************************************
	// IO window edge detection
	// **************************************************************************
	always_ff @(posedge clk32) begin
		old_ioe <= IOE;
		old_iof <= IOF;
	end

	assign stb_ioe = IOE & ~old_ioe;
	assign stb_iof = IOF & ~old_iof;
	assign ioe_wr  = stb_ioe & mem_write;
	assign ioe_rd  = stb_ioe & ~mem_write;

	// **************************************************************************
	// Per-type registers
	// **************************************************************************
	always_ff @(posedge clk32) begin
		init_n <= 1'b1;
		old_id <= cart_id;

		if (reset_n || (old_id != cart_id)) begin
			bank_lo        <= '0;
			bank_hi        <= '0;
			lo_from_table  <= 1'b0;
			hi_from_table  <= 1'b0;
			exrom_override <= 1'b1;
			game_override  <= 1'b1;
			iof_ena        <= 1'b0;
			iof_wr_ena     <= 1'b0;
			init_n         <= 1'b0;
		end else begin
			case (cart_id)
				// 8K, 16K or Ultimax as the CRT header says
				CART_GENERIC: begin
					exrom_override <= cart_exrom[0];
					game_override  <= cart_game[0];
					bank_lo        <= '0;
					bank_hi        <= '0;
					lo_from_table  <= 1'b1;
					hi_from_table  <= 1'b1;
				end
				CART_SIMONS: begin
					if (!init_n) begin
						exrom_override <= 1'b0;
						game_override  <= 1'b0;
						bank_lo        <= 7'd0;
						bank_hi        <= 7'd1;
					end
					// Write selects 16K, read drops back to 8K
					if (ioe_wr)
						game_override <= 1'b0;
					if (ioe_rd)
						game_override <= 1'b1;
				end
				CART_OCEAN: begin
					if (!init_n) begin
						exrom_override <= 1'b0;
						game_override  <= 1'b0;
					end
					if (ioe_wr) begin
						bank_lo <= bank_t'(data_in[5:0]);
						bank_hi <= bank_t'(data_in[5:0]);
					end
					// Large images only use ROML, A000 stays RAM
					if (bank_count > 8'd32)
						game_override <= 1'b1;
				end
				CART_C64GS: begin
					exrom_override <= 1'b0;
					game_override  <= 1'b1;
					if (ioe_rd)
						bank_lo <= '0;
					if (ioe_wr)
						bank_lo <= bank_t'(addr_in[5:0]);
				end
				CART_MAGIC_DESK: begin
					if (!init_n) begin
						exrom_override <= 1'b0;
						game_override  <= 1'b1;
						bank_lo        <= '0;
					end
					if (ioe_wr) begin
						if (bank_count <= 8'd16)
							bank_lo <= bank_t'(data_in[3:0]);
						else if (bank_count <= 8'd32)
							bank_lo <= bank_t'(data_in[4:0]);
						else if (bank_count <= 8'd64)
							bank_lo <= bank_t'(data_in[5:0]);
						else
							bank_lo <= data_in[6:0];
						exrom_override <= data_in[7];
					end
				end
				CART_EASYFLASH, CART_XBANK: begin
					if (!init_n) begin
						// Only type 32 boots in Ultimax
						exrom_override <= (cart_id == CART_EASYFLASH);
						game_override  <= 1'b0;
						iof_ena        <= 1'b1;
						iof_wr_ena     <= 1'b1;
						bank_lo        <= '0;
						bank_hi        <= '0;
						lo_from_table  <= 1'b1;
						hi_from_table  <= 1'b1;
					end
					if (ioe_wr) begin
						if (addr_in[1]) begin
							// Boot jumper assumed in boot position
							game_override  <= ~data_in[0] & data_in[2];
							exrom_override <= ~data_in[1];
						end else begin
							bank_lo <= bank_t'(data_in[5:0]);
							bank_hi <= bank_t'(data_in[5:0]);
						end
					end
				end
				default: ;
			endcase
		end
	end

	assign state.bank_lo        = bank_lo;
	assign state.bank_hi        = bank_hi;
	assign state.lo_from_table  = lo_from_table;
	assign state.hi_from_table  = hi_from_table;
	assign state.exrom_override = exrom_override;
	assign state.game_override  = game_override;
	assign state.iof_ena        = iof_ena;
	assign state.iof_wr_ena     = iof_wr_ena;
	assign state.iof_strobe     = stb_iof;

	assign exrom = exrom_override;
	assign game  = game_override;

endmodule

`default_nettype wire

//--- src/crt_bank_table.sv
// CRT bank location table
`timescale 1ns/10ps
`default_nettype none

module crt_bank_table #(
	parameter int BANK_SLOTS = 64
) (
	input  wire                      clk32,
	input  wire                      cart_loading,
	input  wire                      cart_bank_wr,
	input  wire [15:0]               cart_bank_num,
	input  wire [15:0]               cart_bank_laddr,
	input  wire [15:0]               cart_bank_size,
	input  wire cart_pkg::sdram_addr_t cart_bank_raddr,
	output cart_pkg::bank_count_t    bank_count,
	bank_lookup_if.bank_table        lookup
);
	import cart_pkg::*;

	localparam int IDX_W = $clog2(BANK_SLOTS);

	bank_t lo_table [BANK_SLOTS];
	bank_t hi_table [BANK_SLOTS];

	logic  old_loading;
	logic  load_start;
	bank_t raddr_bank;

	assign load_start = cart_loading & ~old_loading;
	assign raddr_bank = cart_bank_raddr[19:13];

	// Chip packets land here as the image streams in
	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;

		if (cart_bank_wr && (cart_bank_num < BANK_SLOTS)) begin
			if (cart_bank_laddr <= 16'h8000) begin
				lo_table[cart_bank_num[IDX_W-1:0]] <= raddr_bank;
				// Upper half of a 16K packet goes to ROMH
				if (cart_bank_size > 16'h2000)
					hi_table[cart_bank_num[IDX_W-1:0]] <= raddr_bank + 7'd1;
			end else begin
				hi_table[cart_bank_num[IDX_W-1:0]] <= raddr_bank;
			end
		end
	end

	// Loaded bank counter that restarts with each image
	always_ff @(posedge clk32) begin
		if (load_start)
			bank_count <= '0;
		else if (cart_bank_wr)
			bank_count <= bank_count + 8'd1;
	end

	assign lookup.lo_bank = lo_table[lookup.lo_index[IDX_W-1:0]];
	assign lookup.hi_bank = hi_table[lookup.hi_index[IDX_W-1:0]];

endmodule

`default_nettype wire

//--- src/bank_lookup_if.sv
// Bank table lookup
`timescale 1ns/10ps
`default_nettype none

interface bank_lookup_if;
	import cart_pkg::*;

	// CRT bank number per window
	bank_t lo_index;
	bank_t hi_index;

	// SDRAM bank found in the table
	bank_t lo_bank;
	bank_t hi_bank;

	modport bank_table (input lo_index, hi_index, output lo_bank, hi_bank);
	modport translator (output lo_index, hi_index, input lo_bank, hi_bank);

endinterface

`default_nettype wire

//--- src/map_state_if.sv
// Mapper state to translator
`timescale 1ns/10ps
`default_nettype none

interface map_state_if;
	import cart_pkg::*;

	// Window banks, raw SDRAM bank or table index
	bank_t bank_lo;
	bank_t bank_hi;
	logic  lo_from_table;
	logic  hi_from_table;

	// Cartridge lines
	logic  exrom_override;
	logic  game_override;

	// DFxx window control
	logic  iof_ena;
	logic  iof_wr_ena;
	logic  iof_strobe;

	modport mapper (output bank_lo, bank_hi, lo_from_table, hi_from_table,
		exrom_override, game_override, iof_ena, iof_wr_ena, iof_strobe);
	modport translator (input bank_lo, bank_hi, lo_from_table, hi_from_table,
		exrom_override, game_override, iof_ena, iof_wr_ena, iof_strobe);

endinterface

`default_nettype wire

//--- src/cart_pkg.sv
// Cartridge mapper definitions
`default_nettype none

package cart_pkg;

	// Bus and bank widths
	typedef logic [15:0] cart_id_t;
	typedef logic [6:0]  bank_t;
	typedef logic [7:0]  phys_bank_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [22:0] sdram_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [7:0]  bank_count_t;

	// CRT hardware type codes
	localparam cart_id_t CART_GENERIC    = 16'd0;
	localparam cart_id_t CART_SIMONS     = 16'd4;
	localparam cart_id_t CART_OCEAN      = 16'd5;
	localparam cart_id_t CART_C64GS      = 16'd15;
	localparam cart_id_t CART_MAGIC_DESK = 16'd19;
	localparam cart_id_t CART_EASYFLASH  = 16'd32;
	localparam cart_id_t CART_XBANK      = 16'd33;

	// SDRAM layout
	// ROM banks live from 0x100000, RAM banks from 0x010000
	localparam int         ROM_REGION_BIT   = 7;
	localparam phys_bank_t RAM_REGION_BASE  = 8'd8;
	localparam int         BANK_OFFSET_BITS = 13;

endpackage

`default_nettype wire
